//--- src/net_pkg.sv
/*
  shared types and constants for the network control core
  all timing constants are in seconds of the tick timer,
  not in clock cycles
  net_state_t encoding is visible on the net_state output
*/

package net_pkg;

  // ----------------------------------------
  // address acquisition states
  // ----------------------------------------
  typedef enum logic [2:0] {
    st_start        = 3'd0,
    st_link_wait    = 3'd1,
    st_settle       = 3'd2,
    st_dhcp_request = 3'd3,
    st_dhcp_wait    = 3'd4,
    st_dhcp_bound   = 3'd5,
    st_running      = 3'd6
  } net_state_t;

  // granted transmit source, also the priority order
  typedef enum logic [1:0] {
    proto_arp  = 2'd0,
    proto_icmp = 2'd1,
    proto_dhcp = 2'd2,
    proto_udp  = 2'd3
  } tx_proto_t;

  // ----------------------------------------
  // field widths
  // ----------------------------------------
  localparam int IP_W      = 32;
  localparam int MAC_W     = 48;
  localparam int PORT_W    = 16;
  localparam int SEC_CNT_W = 4;

  // default mac, locally administered, bit 1 is patched per board
  localparam logic [MAC_W-1:0] BASE_MAC     = 48'h02_4E_45_54_00_01;
  localparam logic [15:0]      APIPA_PREFIX = {8'd169, 8'd254};

  // seconds based delays
  localparam logic [SEC_CNT_W-1:0] SETTLE_S       = 4'd1;
  localparam logic [SEC_CNT_W-1:0] DHCP_RETRY_1_S = 4'd1;
  localparam logic [SEC_CNT_W-1:0] DHCP_RETRY_2_S = 4'd3;
  localparam logic [SEC_CNT_W-1:0] DHCP_RETRY_3_S = 4'd7;
  localparam logic [SEC_CNT_W-1:0] DHCP_GIVE_UP_S = 4'd15;
  // 12 hours, used when the server grants a zero lease
  localparam logic [31:0]          DEFAULT_RENEW_S = 32'd43_200;

  // well known ports
  localparam logic [PORT_W-1:0] DHCP_CLIENT_PORT = 16'd68;
  localparam logic [PORT_W-1:0] DHCP_SERVER_PORT = 16'd67;
  localparam logic [PORT_W-1:0] DATA_SRC_PORT    = 16'd1024;

  localparam logic [IP_W-1:0]  BROADCAST_IP  = '1;
  localparam logic [MAC_W-1:0] BROADCAST_MAC = '1;

endpackage

//--- src/second_timer.sv
/*
  one second tick source for the address state machine
  ticks_per_second must be 2 or more
  restart zeroes the count, first pulse follows a full second later
*/

`timescale 1ns/1ps

module second_timer #(
  parameter int ticks_per_second = 125_000_000
) (
  input  logic tx_clock,
  input  logic rst_n,
  input  logic restart,
  output logic sec_pulse
);

  // cycle count inside the current second
  logic [$clog2(ticks_per_second)-1:0] count;
  logic                                last_tick;

  assign last_tick = (count == ($clog2(ticks_per_second))'(ticks_per_second - 1));

  always_ff @(posedge tx_clock) begin
    if (!rst_n || restart) begin
      count     <= '0;
      sec_pulse <= 1'b0;
    end else begin
      // wrap and flag the second boundary
      sec_pulse <= last_tick;
      count     <= last_tick ? '0 : count + 1'b1;
    end
  end

endmodule

//--- src/net_config.sv
/*
  configuration registers beside the address fsm
  static_ip of zero or all ones means "use dhcp"
  run_dest_* follow the udp destination one cycle late
  while run is low and freeze while run is high
*/

`timescale 1ns/1ps

module net_config import net_pkg::*; (
  input  logic              tx_clock,
  input  logic              rst_n,
  input  logic              cfg_write,
  input  logic [IP_W-1:0]   cfg_ip,
  input  logic              mac_bit,
  input  logic              run,
  input  logic [IP_W-1:0]   udp_dest_ip,
  input  logic [MAC_W-1:0]  udp_dest_mac,
  input  logic [PORT_W-1:0] udp_dest_port,
  output logic [IP_W-1:0]   static_ip,
  output logic [MAC_W-1:0]  local_mac,
  output logic [IP_W-1:0]   run_dest_ip,
  output logic [MAC_W-1:0]  run_dest_mac,
  output logic [PORT_W-1:0] run_dest_port
);

  // software written static address
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      static_ip <= '0;
    end else if (cfg_write) begin
      static_ip <= cfg_ip;
    end
  end

  // board strap inverts mac bit 1
  assign local_mac = {BASE_MAC[MAC_W-1:2], ~mac_bit, BASE_MAC[0]};

  // ----------------------------------------
  // udp peer latch
  // ----------------------------------------
  // a running stream keeps its peer
  always_ff @(posedge tx_clock) begin
    if (!run) begin
      run_dest_ip   <= udp_dest_ip;
      run_dest_mac  <= udp_dest_mac;
      run_dest_port <= udp_dest_port;
    end
  end

endmodule

//--- src/addr_fsm.sv
/*
  address acquisition: static ip, dhcp with retries, apipa fallback
  all delays are counted in sec_pulse seconds, so they carry
  up to one second of jitter after each timer restart
  seconds are only counted in st_dhcp_wait, not while a request
  is waiting for the arbiter
  link loss from any state past st_link_wait goes back to st_link_wait
*/

`timescale 1ns/1ps

module addr_fsm import net_pkg::*; (
  input  logic             tx_clock,
  input  logic             rst_n,
  input  logic             link_up,
  input  logic [IP_W-1:0]  static_ip,
  input  logic [MAC_W-1:0] local_mac,
  input  logic             sec_pulse,
  input  logic             offer_valid,
  input  logic [IP_W-1:0]  offer_ip,
  input  logic [31:0]      offer_lease,
  output logic             dhcp_req_valid,
  input  logic             dhcp_req_ready,
  output logic             timer_restart,
  output logic [IP_W-1:0]  local_ip,
  output net_state_t       net_state,
  output logic             dhcp_active,
  output logic             dhcp_timeout
);

  net_state_t           state;
  logic [SEC_CNT_W-1:0] sec_cnt;
  logic [SEC_CNT_W-1:0] sec_next;
  logic [31:0]          renew_cnt;
  logic                 static_ok;
  logic                 dhcp_retry;
  logic [IP_W-1:0]      apipa_ip;
  logic                 sec_tick;

  assign sec_next  = sec_cnt + 1'b1;
  // zero and all ones both mean unconfigured
  assign static_ok = (static_ip != '0) && (static_ip != '1);
  assign apipa_ip  = {APIPA_PREFIX, local_mac[15:0]};
  assign dhcp_retry = (sec_next == DHCP_RETRY_1_S) || (sec_next == DHCP_RETRY_2_S) ||
                      (sec_next == DHCP_RETRY_3_S);
  // a pulse from the second before a restart does not count
  assign sec_tick  = sec_pulse && !timer_restart;

  // ----------------------------------------
  // state register
  // ----------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state         <= st_start;
      local_ip      <= '0;
      sec_cnt       <= '0;
      renew_cnt     <= '0;
      timer_restart <= 1'b0;
    end else begin
      timer_restart <= 1'b0;
      if (!link_up && state != st_start && state != st_link_wait) begin
        // link lost, start over once it returns
        state   <= st_link_wait;
        sec_cnt <= '0;
      end else begin
        case (state)
          st_start: begin
            state <= st_link_wait;
          end

          st_link_wait: begin
            sec_cnt <= '0;
            if (link_up) begin
              state         <= st_settle;
              timer_restart <= 1'b1;
            end
          end

          // let the link settle before choosing an address
          st_settle: begin
            if (sec_tick) begin
              if (sec_next == SETTLE_S) begin
                sec_cnt <= '0;
                if (static_ok) begin
                  local_ip <= static_ip;
                  state    <= st_running;
                end else begin
                  // dhcp discover goes out from 0.0.0.0
                  local_ip      <= '0;
                  state         <= st_dhcp_request;
                  timer_restart <= 1'b1;
                end
              end else begin
                sec_cnt <= sec_next;
              end
            end
          end

          // hold the request until the arbiter takes it
          st_dhcp_request: begin
            if (dhcp_req_ready) begin
              state <= st_dhcp_wait;
            end
          end

          st_dhcp_wait: begin
            if (offer_valid) begin
              local_ip      <= offer_ip;
              sec_cnt       <= '0;
              timer_restart <= 1'b1;
              // renew at half the lease
              renew_cnt     <= (offer_lease == '0) ? DEFAULT_RENEW_S : (offer_lease >> 1);
              state         <= st_dhcp_bound;
            end else if (sec_tick) begin
              sec_cnt <= sec_next;
              if (sec_next == DHCP_GIVE_UP_S) begin
                // no server answered, self assign
                local_ip <= apipa_ip;
                state    <= st_running;
              end else if (dhcp_retry) begin
                // retransmit at 1, 3, 7 s
                state <= st_dhcp_request;
              end
            end
          end

          // lease held, count down to renewal
          st_dhcp_bound: begin
            if (renew_cnt == '0) begin
              state         <= st_dhcp_request;
              timer_restart <= 1'b1;
            end else if (sec_tick) begin
              renew_cnt <= renew_cnt - 1'b1;
            end
          end

          st_running: begin
            // ends the one cycle timeout flag after apipa
            sec_cnt <= '0;
          end

          default: begin
            state <= st_start;
          end
        endcase
      end
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign net_state      = state;
  assign dhcp_req_valid = (state == st_dhcp_request);
  assign dhcp_active    = (state == st_dhcp_request) || (state == st_dhcp_wait);
  assign dhcp_timeout   = (sec_cnt == DHCP_GIVE_UP_S);

endmodule

//--- src/tx_arbiter.sv
/*
  fixed priority transmit arbiter: arp, icmp, dhcp, udp
  one frame in flight, from grant until frame_done
  source ready is a one cycle grant, valid must be held until then
  frame_done is only honoured after frame_ready has been seen
*/

`timescale 1ns/1ps

module tx_arbiter import net_pkg::*; (
  input  logic              tx_clock,
  input  logic              rst_n,
  input  logic              arp_valid,
  output logic              arp_ready,
  input  logic [MAC_W-1:0]  arp_dest_mac,
  input  logic              icmp_valid,
  output logic              icmp_ready,
  input  logic [IP_W-1:0]   icmp_dest_ip,
  input  logic [MAC_W-1:0]  icmp_dest_mac,
  input  logic              dhcp_req_valid,
  output logic              dhcp_req_ready,
  input  logic              udp_valid,
  output logic              udp_ready,
  input  logic [IP_W-1:0]   run_dest_ip,
  input  logic [MAC_W-1:0]  run_dest_mac,
  input  logic [PORT_W-1:0] run_dest_port,
  output logic              frame_valid,
  input  logic              frame_ready,
  input  logic              frame_done,
  output tx_proto_t         frame_proto,
  output logic [IP_W-1:0]   frame_dest_ip,
  output logic [MAC_W-1:0]  frame_dest_mac,
  output logic [PORT_W-1:0] frame_src_port,
  output logic [PORT_W-1:0] frame_dest_port
);

  logic              busy;
  logic              grant;
  logic              grant_any;
  tx_proto_t         grant_proto;
  logic [IP_W-1:0]   grant_ip;
  logic [MAC_W-1:0]  grant_mac;
  logic [PORT_W-1:0] grant_src;
  logic [PORT_W-1:0] grant_dst;

  // ----------------------------------------
  // priority select and header fields
  // ----------------------------------------
  always_comb begin
    grant_any   = 1'b1;
    grant_proto = proto_arp;
    grant_ip    = '0;
    grant_mac   = arp_dest_mac;
    grant_src   = '0;
    grant_dst   = '0;
    if (arp_valid) begin
      // arp reply, mac only
      grant_proto = proto_arp;
    end else if (icmp_valid) begin
      grant_proto = proto_icmp;
      grant_ip    = icmp_dest_ip;
      grant_mac   = icmp_dest_mac;
    end else if (dhcp_req_valid) begin
      // discover and request are broadcast
      grant_proto = proto_dhcp;
      grant_ip    = BROADCAST_IP;
      grant_mac   = BROADCAST_MAC;
      grant_src   = DHCP_CLIENT_PORT;
      grant_dst   = DHCP_SERVER_PORT;
    end else if (udp_valid) begin
      grant_proto = proto_udp;
      grant_ip    = run_dest_ip;
      grant_mac   = run_dest_mac;
      grant_src   = DATA_SRC_PORT;
      grant_dst   = run_dest_port;
    end else begin
      grant_any = 1'b0;
    end
  end

  assign grant = !busy && grant_any;

  // one hot ready pulse toward the winner
  assign arp_ready      = grant && (grant_proto == proto_arp);
  assign icmp_ready     = grant && (grant_proto == proto_icmp);
  assign dhcp_req_ready = grant && (grant_proto == proto_dhcp);
  assign udp_ready      = grant && (grant_proto == proto_udp);

  // ----------------------------------------
  // frame in flight
  // ----------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      frame_valid <= 1'b0;
    end else if (grant) begin
      busy        <= 1'b1;
      frame_valid <= 1'b1;
    end else if (frame_valid && frame_ready) begin
      frame_valid <= 1'b0;
    end else if (busy && !frame_valid && frame_done) begin
      // sender finished, idle next cycle
      busy <= 1'b0;
    end
  end

  // header capture at grant, held until the next one
  always_ff @(posedge tx_clock) begin
    if (grant) begin
      frame_proto     <= grant_proto;
      frame_dest_ip   <= grant_ip;
      frame_dest_mac  <= grant_mac;
      frame_src_port  <= grant_src;
      frame_dest_port <= grant_dst;
    end
  end

endmodule

//--- src/network_top.sv
/*
  network control core, single tx_clock domain
  receive side inputs (offers, udp peer) must already be
  synchronous to tx_clock
  ticks_per_second sets the length of one protocol second
*/

`timescale 1ns/1ps

module network_top import net_pkg::*; #(
  parameter int ticks_per_second = 125_000_000
) (
  input  logic              tx_clock,
  input  logic              rst_n,
  // configuration
  input  logic              cfg_write,
  input  logic [IP_W-1:0]   cfg_ip,
  input  logic              mac_bit,
  input  logic              run,
  input  logic [IP_W-1:0]   udp_dest_ip,
  input  logic [MAC_W-1:0]  udp_dest_mac,
  input  logic [PORT_W-1:0] udp_dest_port,
  // link and dhcp receive
  input  logic              link_up,
  input  logic              offer_valid,
  input  logic [IP_W-1:0]   offer_ip,
  input  logic [31:0]       offer_lease,
  // transmit sources
  input  logic              arp_valid,
  output logic              arp_ready,
  input  logic [MAC_W-1:0]  arp_dest_mac,
  input  logic              icmp_valid,
  output logic              icmp_ready,
  input  logic [IP_W-1:0]   icmp_dest_ip,
  input  logic [MAC_W-1:0]  icmp_dest_mac,
  input  logic              udp_valid,
  output logic              udp_ready,
  // frame sender
  output logic              frame_valid,
  input  logic              frame_ready,
  input  logic              frame_done,
  output tx_proto_t         frame_proto,
  output logic [IP_W-1:0]   frame_dest_ip,
  output logic [MAC_W-1:0]  frame_dest_mac,
  output logic [PORT_W-1:0] frame_src_port,
  output logic [PORT_W-1:0] frame_dest_port,
  // status
  output logic [IP_W-1:0]   local_ip,
  output logic [MAC_W-1:0]  local_mac,
  output net_state_t        net_state,
  output logic              dhcp_active,
  output logic              dhcp_timeout
);

  logic              sec_pulse;
  logic              timer_restart;
  logic [IP_W-1:0]   static_ip;
  logic              dhcp_req_valid;
  logic              dhcp_req_ready;
  logic [IP_W-1:0]   run_dest_ip;
  logic [MAC_W-1:0]  run_dest_mac;
  logic [PORT_W-1:0] run_dest_port;

  // ----------------------------------------
  // time base
  // ----------------------------------------
  second_timer #(
    .ticks_per_second(ticks_per_second)
  ) u_second_timer (
    .tx_clock (tx_clock),
    .rst_n    (rst_n),
    .restart  (timer_restart),
    .sec_pulse(sec_pulse)
  );

  net_config u_net_config (
    .tx_clock     (tx_clock),
    .rst_n        (rst_n),
    .cfg_write    (cfg_write),
    .cfg_ip       (cfg_ip),
    .mac_bit      (mac_bit),
    .run          (run),
    .udp_dest_ip  (udp_dest_ip),
    .udp_dest_mac (udp_dest_mac),
    .udp_dest_port(udp_dest_port),
    .static_ip    (static_ip),
    .local_mac    (local_mac),
    .run_dest_ip  (run_dest_ip),
    .run_dest_mac (run_dest_mac),
    .run_dest_port(run_dest_port)
  );

  // ----------------------------------------
  // address acquisition
  // ----------------------------------------
  addr_fsm u_addr_fsm (
    .tx_clock      (tx_clock),
    .rst_n         (rst_n),
    .link_up       (link_up),
    .static_ip     (static_ip),
    .local_mac     (local_mac),
    .sec_pulse     (sec_pulse),
    .offer_valid   (offer_valid),
    .offer_ip      (offer_ip),
    .offer_lease   (offer_lease),
    .dhcp_req_valid(dhcp_req_valid),
    .dhcp_req_ready(dhcp_req_ready),
    .timer_restart (timer_restart),
    .local_ip      (local_ip),
    .net_state     (net_state),
    .dhcp_active   (dhcp_active),
    .dhcp_timeout  (dhcp_timeout)
  );

  // dhcp requests share the arbiter with the external sources
  tx_arbiter u_tx_arbiter (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .arp_valid      (arp_valid),
    .arp_ready      (arp_ready),
    .arp_dest_mac   (arp_dest_mac),
    .icmp_valid     (icmp_valid),
    .icmp_ready     (icmp_ready),
    .icmp_dest_ip   (icmp_dest_ip),
    .icmp_dest_mac  (icmp_dest_mac),
    .dhcp_req_valid (dhcp_req_valid),
    .dhcp_req_ready (dhcp_req_ready),
    .udp_valid      (udp_valid),
    .udp_ready      (udp_ready),
    .run_dest_ip    (run_dest_ip),
    .run_dest_mac   (run_dest_mac),
    .run_dest_port  (run_dest_port),
    .frame_valid    (frame_valid),
    .frame_ready    (frame_ready),
    .frame_done     (frame_done),
    .frame_proto    (frame_proto),
    .frame_dest_ip  (frame_dest_ip),
    .frame_dest_mac (frame_dest_mac),
    .frame_src_port (frame_src_port),
    .frame_dest_port(frame_dest_port)
  );

endmodule

//--- tb/network_top_props.sv
/*
  concurrent checks on the transmit handshakes and the address fsm
  bound into network_top so the internal dhcp request wires are visible
  a frame is in flight from frame_valid until its frame_done pulse
*/

`timescale 1ns/1ps

module network_top_props import net_pkg::*; (
  input logic              tx_clock,
  input logic              rst_n,
  input logic              arp_ready,
  input logic              icmp_ready,
  input logic              dhcp_req_ready,
  input logic              udp_ready,
  input logic              frame_valid,
  input logic              frame_ready,
  input logic              frame_done,
  input tx_proto_t         frame_proto,
  input logic [IP_W-1:0]   frame_dest_ip,
  input logic [MAC_W-1:0]  frame_dest_mac,
  input logic [PORT_W-1:0] frame_src_port,
  input logic [PORT_W-1:0] frame_dest_port,
  input logic [IP_W-1:0]   static_ip,
  input logic [IP_W-1:0]   local_ip,
  input net_state_t        net_state
);

  logic [3:0] readies;
  logic       static_bad;
  logic       in_flight;

  assign readies    = {arp_ready, icmp_ready, dhcp_req_ready, udp_ready};
  assign static_bad = (static_ip == '0) || (static_ip == '1);

  // accepted frame still owned by the sender until frame_done
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      in_flight <= 1'b0;
    end else if (frame_done) begin
      in_flight <= 1'b0;
    end else if (frame_valid) begin
      in_flight <= 1'b1;
    end
  end

  // one grant at a time
  a_one_ready: assert property (@(posedge tx_clock) disable iff (!rst_n)
    $onehot0(readies))
    else $error("more than one source ready in the same cycle");

  // ----------------------------------------
  // back-pressure holds the frame
  // ----------------------------------------
  a_hold: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (frame_valid && !frame_ready) |=> (frame_valid && $stable(frame_proto) &&
      $stable(frame_dest_ip) && $stable(frame_dest_mac) &&
      $stable(frame_src_port) && $stable(frame_dest_port)))
    else $error("frame header changed under back-pressure");

  a_no_grant: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (frame_valid || in_flight) |-> (readies == 4'b0000))
    else $error("source granted while a frame is in flight");

  // first request after settle goes out from 0.0.0.0
  a_zero_ip: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (net_state == st_dhcp_request && $past(net_state) == st_settle && static_bad)
      |-> (local_ip == '0))
    else $error("local ip not cleared on the first dhcp request");

endmodule

bind network_top network_top_props u_props (
  .tx_clock       (tx_clock),
  .rst_n          (rst_n),
  .arp_ready      (arp_ready),
  .icmp_ready     (icmp_ready),
  .dhcp_req_ready (dhcp_req_ready),
  .udp_ready      (udp_ready),
  .frame_valid    (frame_valid),
  .frame_ready    (frame_ready),
  .frame_done     (frame_done),
  .frame_proto    (frame_proto),
  .frame_dest_ip  (frame_dest_ip),
  .frame_dest_mac (frame_dest_mac),
  .frame_src_port (frame_src_port),
  .frame_dest_port(frame_dest_port),
  .static_ip      (static_ip),
  .local_ip       (local_ip),
  .net_state      (net_state)
);

//--- tb/network_top_tb.sv
/*
  testbench for network_top with 16 cycle seconds
  covers static ip, dhcp offer, dhcp timeout to apipa, lease renewal,
  arbitration order with the udp run latch, and link loss
  sender delays come from a table filled from the seeded generator
*/

`timescale 1ns/1ps

module network_top_tb import net_pkg::*;;

  logic              tx_clock;
  logic              rst_n;
  logic              cfg_write, mac_bit, run, link_up;
  logic [IP_W-1:0]   cfg_ip, udp_dest_ip, offer_ip, icmp_dest_ip;
  logic [MAC_W-1:0]  udp_dest_mac, arp_dest_mac, icmp_dest_mac;
  logic [PORT_W-1:0] udp_dest_port;
  logic              offer_valid;
  logic [31:0]       offer_lease;
  logic              arp_valid, icmp_valid, udp_valid;
  logic              arp_ready, icmp_ready, udp_ready;
  logic              frame_valid, frame_ready, frame_done;
  tx_proto_t         frame_proto;
  logic [IP_W-1:0]   frame_dest_ip, local_ip;
  logic [MAC_W-1:0]  frame_dest_mac, local_mac;
  logic [PORT_W-1:0] frame_src_port, frame_dest_port;
  net_state_t        net_state;
  logic              dhcp_active, dhcp_timeout;

  int        seed = 10895;
  int        delay_table [64];
  int        test_errors = 0;
  int        frame_errors = 0;
  int        timeouts = 0;
  int        dhcp_frames = 0;
  int        timeout_pulses = 0;
  tx_proto_t accepted [$];
  // udp peer that the run latch should hold
  logic [IP_W-1:0]   peer_ip;
  logic [MAC_W-1:0]  peer_mac;
  logic [PORT_W-1:0] peer_port;
  logic [111:0]      hdr;
  int                bad;

  network_top #(.ticks_per_second(16)) UUT (.*);

  initial begin
    tx_clock = 1'b0;
    forever #4 tx_clock = ~tx_clock;
  end

  // ----------------------------------------
  // reference, checks, waits
  // ----------------------------------------
  // {dest ip, dest mac, src port, dest port}
  function automatic logic [111:0] expected_header(tx_proto_t proto, logic [47:0] a_mac,
      logic [31:0] i_ip, logic [47:0] i_mac, logic [31:0] p_ip, logic [47:0] p_mac,
      logic [15:0] p_port);
    case (proto)
      proto_arp:  return {32'h0, a_mac, 16'h0, 16'h0};
      proto_icmp: return {i_ip, i_mac, 16'h0, 16'h0};
      proto_dhcp: return {32'hffff_ffff, 48'hffff_ffff_ffff, 16'd68, 16'd67};
      default:    return {p_ip, p_mac, 16'd1024, p_port};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
      input logic [63:0] actual, output int fails);
    fails = 0;
    if (expected !== actual) begin
      fails = 1;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic note_timeout(input string what, input int limit);
    timeouts++;
    $display("Timeout: %s did not happen within %0d cycles", what, limit);
  endtask

  task automatic wait_for_state(input net_state_t target, input int limit, input string what);
    int n;
    n = 0;
    while (net_state != target && n < limit) begin
      @(posedge tx_clock);
      n++;
    end
    if (net_state != target) note_timeout(what, limit);
    #1;
  endtask

  // counters move at the clock edge, read them just after
  task automatic wait_for_dhcp(input int target, input int limit, output int cycles);
    cycles = 0;
    while (dhcp_frames < target && cycles < limit) begin
      @(posedge tx_clock);
      #1;
      cycles++;
    end
    if (dhcp_frames < target) note_timeout("dhcp frame", limit);
  endtask

  task automatic wait_for_frames(input int target, input int limit);
    int n;
    n = 0;
    while (accepted.size() < target && n < limit) begin
      @(posedge tx_clock);
      #1;
      n++;
    end
    if (accepted.size() < target) note_timeout("accepted frames", limit);
  endtask

  // drop each source valid after its one cycle ready
  task automatic serve_sources(input int limit);
    int   n;
    logic got_arp;
    logic got_icmp;
    logic got_udp;
    n = 0;
    while ((arp_valid || icmp_valid || udp_valid) && n < limit) begin
      // ready is combinational, settled by mid cycle
      @(negedge tx_clock);
      got_arp  = arp_ready;
      got_icmp = icmp_ready;
      got_udp  = udp_ready;
      @(posedge tx_clock);
      #1;
      if (got_arp) arp_valid = 1'b0;
      if (got_icmp) icmp_valid = 1'b0;
      if (got_udp) udp_valid = 1'b0;
      n++;
    end
    if (arp_valid || icmp_valid || udp_valid) note_timeout("source grants", limit);
  endtask

  // link down, let the sender drain, then reset
  task automatic restart_dut();
    int n;
    link_up = 1'b0;
    n = 0;
    while (frame_valid && n < 50) begin
      @(posedge tx_clock);
      n++;
    end
    if (frame_valid) note_timeout("frame drain", 50);
    repeat (8) @(posedge tx_clock);
    #1;
    rst_n = 1'b0;
    repeat (5) @(posedge tx_clock);
    #1;
    rst_n = 1'b1;
  endtask

  // ----------------------------------------
  // frame sender model
  // ----------------------------------------
  initial begin
    int idx;
    idx = 0;
    frame_ready = 1'b0;
    frame_done  = 1'b0;
    forever begin
      @(posedge tx_clock);
      if (rst_n && frame_valid) begin
        repeat (delay_table[idx % 64]) @(posedge tx_clock);
        idx++;
        #1 frame_ready = 1'b1;
        @(posedge tx_clock);
        #1 frame_ready = 1'b0;
        @(posedge tx_clock);
        #1 frame_done = 1'b1;
        @(posedge tx_clock);
        #1 frame_done = 1'b0;
      end
    end
  end

  // compare every accepted frame with the reference
  always @(posedge tx_clock) begin
    if (rst_n && frame_valid && frame_ready) begin
      hdr = expected_header(frame_proto, arp_dest_mac, icmp_dest_ip, icmp_dest_mac,
                            peer_ip, peer_mac, peer_port);
      check_value({frame_proto.name(), " dest ip"}, 64'(hdr[111:80]), 64'(frame_dest_ip), bad);
      frame_errors += bad;
      check_value({frame_proto.name(), " dest mac"}, 64'(hdr[79:32]), 64'(frame_dest_mac), bad);
      frame_errors += bad;
      check_value({frame_proto.name(), " src port"}, 64'(hdr[31:16]), 64'(frame_src_port), bad);
      frame_errors += bad;
      check_value({frame_proto.name(), " dest port"}, 64'(hdr[15:0]), 64'(frame_dest_port), bad);
      frame_errors += bad;
      accepted.push_back(frame_proto);
      if (frame_proto == proto_dhcp) dhcp_frames++;
    end
    if (rst_n && dhcp_timeout) timeout_pulses++;
  end

  initial begin
    #200us;
    $display("Timeout: simulation watchdog expired");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int f;
    int base;
    int cycles;
    logic [IP_W-1:0] ip;
    for (int i = 0; i < 64; i++) delay_table[i] = $unsigned($random(seed)) % 4;
    rst_n = 1'b0;
    cfg_write = 1'b0;
    cfg_ip = '0;
    mac_bit = 1'b0;
    run = 1'b0;
    link_up = 1'b0;
    udp_dest_ip = '0;
    udp_dest_mac = '0;
    udp_dest_port = '0;
    offer_valid = 1'b0;
    offer_ip = '0;
    offer_lease = '0;
    arp_valid = 1'b0;
    arp_dest_mac = '0;
    icmp_valid = 1'b0;
    icmp_dest_ip = '0;
    icmp_dest_mac = '0;
    udp_valid = 1'b0;
    peer_ip = '0;
    peer_mac = '0;
    peer_port = '0;
    repeat (5) @(posedge tx_clock);
    #1 rst_n = 1'b1;

    // static path
    ip = $random(seed);
    if (ip == '0 || ip == '1) ip = 32'h0a00_0001;
    cfg_ip = ip;
    cfg_write = 1'b1;
    @(posedge tx_clock);
    #1 cfg_write = 1'b0;
    link_up = 1'b1;
    wait_for_state(st_running, 200, "static st_running");
    check_value("static ip", 64'(ip), 64'(local_ip), f);
    test_errors += f;
    check_value("dhcp active on static", 64'd0, 64'(dhcp_active), f);
    test_errors += f;
    // mac_bit low sets mac bit 1
    check_value("local mac strap low", {16'h0, 48'h02_4E_45_54_00_03}, 64'(local_mac), f);
    test_errors += f;

    // link loss and recovery
    link_up = 1'b0;
    wait_for_state(st_link_wait, 20, "st_link_wait after link loss");
    link_up = 1'b1;
    wait_for_state(st_settle, 20, "st_settle after link return");
    wait_for_state(st_running, 200, "st_running after link return");
    check_value("static ip after relink", 64'(ip), 64'(local_ip), f);
    test_errors += f;

    // arbitration order, udp peer frozen by run
    arp_dest_mac  = {16'($random(seed)), 32'($random(seed))};
    icmp_dest_ip  = $random(seed);
    icmp_dest_mac = {16'($random(seed)), 32'($random(seed))};
    udp_dest_ip   = $random(seed);
    udp_dest_mac  = {16'($random(seed)), 32'($random(seed))};
    udp_dest_port = 16'($random(seed));
    peer_ip   = udp_dest_ip;
    peer_mac  = udp_dest_mac;
    peer_port = udp_dest_port;
    @(posedge tx_clock);
    #1 run = 1'b1;
    udp_dest_ip   = ~peer_ip;
    udp_dest_mac  = ~peer_mac;
    udp_dest_port = ~peer_port;
    @(posedge tx_clock);
    #1;
    base = accepted.size();
    arp_valid  = 1'b1;
    icmp_valid = 1'b1;
    udp_valid  = 1'b1;
    serve_sources(100);
    wait_for_frames(base + 3, 100);
    if (accepted.size() >= base + 3) begin
      check_value("grant 1 proto", 64'(proto_arp), 64'(accepted[base]), f);
      test_errors += f;
      check_value("grant 2 proto", 64'(proto_icmp), 64'(accepted[base + 1]), f);
      test_errors += f;
      check_value("grant 3 proto", 64'(proto_udp), 64'(accepted[base + 2]), f);
      test_errors += f;
    end
    run = 1'b0;

    // dhcp success with a 4 second lease
    restart_dut();
    base = dhcp_frames;
    link_up = 1'b1;
    wait_for_dhcp(base + 1, 300, cycles);
    wait_for_state(st_dhcp_wait, 50, "st_dhcp_wait");
    check_value("dhcp active while waiting", 64'd1, 64'(dhcp_active), f);
    test_errors += f;
    ip = $random(seed);
    offer_ip = ip;
    offer_lease = 32'd4;
    offer_valid = 1'b1;
    @(posedge tx_clock);
    #1 offer_valid = 1'b0;
    wait_for_state(st_dhcp_bound, 10, "st_dhcp_bound");
    check_value("offer ip", 64'(ip), 64'(local_ip), f);
    test_errors += f;
    check_value("dhcp active when bound", 64'd0, 64'(dhcp_active), f);
    test_errors += f;

    // renewal at half the lease, two seconds plus a second of slack
    base = dhcp_frames;
    wait_for_dhcp(base + 1, 48, cycles);
    if (cycles < 32) begin
      test_errors++;
      $display("renewal frame came after %0d cycles, earlier than two seconds", cycles);
    end
    check_value("ip kept on renewal", 64'(ip), 64'(local_ip), f);
    test_errors += f;

    // no offer, fall back to apipa
    restart_dut();
    mac_bit = 1'b1;
    base = dhcp_frames;
    cycles = timeout_pulses;
    link_up = 1'b1;
    wait_for_state(st_running, 600, "st_running after dhcp give up");
    repeat (2) @(posedge tx_clock);
    #1;
    check_value("dhcp frames before give up", 64'd4, 64'(dhcp_frames - base), f);
    test_errors += f;
    check_value("local mac", {16'h0, 48'h02_4E_45_54_00_01}, 64'(local_mac), f);
    test_errors += f;
    check_value("apipa ip", 64'({16'ha9fe, 16'h0001}), 64'(local_ip), f);
    test_errors += f;
    check_value("timeout pulses", 64'd1, 64'(timeout_pulses - cycles), f);
    test_errors += f;

    $display("errors: %0d test, %0d frame, %0d timeouts", test_errors, frame_errors, timeouts);
    if (test_errors == 0 && frame_errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- network_top.f
src/net_pkg.sv
src/second_timer.sv
src/net_config.sv
src/addr_fsm.sv
src/tx_arbiter.sv
src/network_top.sv
tb/network_top_props.sv
tb/network_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the network_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f network_top.f \
  --top-module network_top_tb -o sim_network_top > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
( ./obj_dir/sim_network_top > sim.log 2>&1 || echo "TESTBENCH FAILED" >> sim.log )
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
